//--- core_cfg.svh
// ----------------------------------------------------------------------
// core configuration macros
// data width, register file size, boot address and trap vector
// ----------------------------------------------------------------------

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address width
`define XLEN 32

// integer register file
`define NR_REGS 32
`define REG_ADDR_W 5

// pc after reset
`define BOOT_ADDR 32'h0000_0000

// pc after an illegal instruction commits
`define TRAP_VECTOR 32'h0000_0100

`endif

//--- core_pkg.sv
// ----------------------------------------------------------------------
// shared types of the core
// words, register numbers, opcodes, alu operations, fetch entries
// ----------------------------------------------------------------------

`default_nettype none

`include "core_cfg.svh"

package core_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

  // major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // ----------------------------------------------------------------------
  // alu operations, branch compares included
  // ----------------------------------------------------------------------
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,
    ALU_LINK,
    ALU_BEQ,
    ALU_BNE
  } alu_op_e;

  // one fetched word with its pc
  typedef struct packed {
    logic        valid;
    xlen_t       pc;
    logic [31:0] instr;
  } fetch_entry_t;

  // source operands after bypass
  typedef struct packed {
    xlen_t a;
    xlen_t b;
  } operands_t;

endpackage

`default_nettype wire

//--- core_ifs.sv
// ----------------------------------------------------------------------
// stage-to-stage interfaces
// issue_if   decode to execute
// commit_if  execute to commit, also seen by decode for bypass
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface issue_if import core_pkg::*; ();
  logic     valid;
  xlen_t    pc;
  alu_op_e  alu_op;
  reg_idx_t rd;
  logic     rd_we;
  xlen_t    operand_a;
  xlen_t    operand_b;
  xlen_t    branch_target;
  logic     illegal;

  modport issue_src (output valid, pc, alu_op, rd, rd_we, operand_a, operand_b,
                     branch_target, illegal);
  modport issue_dst (input valid, pc, alu_op, rd, rd_we, operand_a, operand_b,
                     branch_target, illegal);
endinterface

interface commit_if import core_pkg::*; ();
  logic     valid;
  xlen_t    pc;
  reg_idx_t rd;
  logic     we;
  xlen_t    result;
  logic     illegal;

  modport ex_src     (output valid, pc, rd, we, result, illegal);
  modport commit_dst (input valid, pc, rd, we, result, illegal);
  // read-only view for operand bypass
  modport fwd_view   (input valid, pc, rd, we, result, illegal);
endinterface

`default_nettype wire

//--- frontend.sv
// ----------------------------------------------------------------------
// frontend
// pc register, redirect selection, fetch entry towards decode
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module frontend import core_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // redirects from execute and commit
  input  logic         branch_redirect_i,
  input  xlen_t        branch_target_i,
  input  logic         exc_redirect_i,
  // instruction port, one cycle read latency
  output xlen_t        imem_addr_o,
  input  logic [31:0]  imem_rdata_i,
  // to decode
  output fetch_entry_t fetch_entry_o
);

  xlen_t pc_q, pc_d;
  xlen_t fetch_pc_q;
  logic  fetch_valid_q;

  assign imem_addr_o = pc_q;

  // exception wins, it belongs to the older instruction
  always_comb begin
    if (exc_redirect_i) begin
      pc_d = `TRAP_VECTOR;
    end else if (branch_redirect_i) begin
      pc_d = branch_target_i;
    end else begin
      pc_d = pc_q + xlen_t'(4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q          <= `BOOT_ADDR;
      fetch_valid_q <= 1'b0;
    end else begin
      pc_q          <= pc_d;
      // word requested in a redirect cycle is on the wrong path
      fetch_valid_q <= ~(exc_redirect_i | branch_redirect_i);
    end
  end

  // pc travels alongside the word coming back from memory
  always_ff @(posedge clk_i) begin
    fetch_pc_q <= pc_q;
  end

  always_comb begin
    fetch_entry_o.valid = fetch_valid_q;
    fetch_entry_o.pc    = fetch_pc_q;
    fetch_entry_o.instr = imem_rdata_i;
  end

endmodule

`default_nettype wire

//--- id_stage.sv
// ----------------------------------------------------------------------
// decode and issue stage
// decoder, register file, operand bypass, issue register
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module id_stage import core_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  fetch_entry_t      fetch_entry_i,
  input  logic              flush_i,
  // register write port from commit
  input  logic              wb_we_i,
  input  reg_idx_t          wb_rd_i,
  input  xlen_t             wb_data_i,
  // execute result for bypass
  commit_if.fwd_view        ex_fwd_i,
  issue_if.issue_src        issue
);

  logic [31:0] instr;
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_idx_t    rs1, rs2, rd;
  xlen_t       imm_i, imm_u, imm_b, imm_j;
  xlen_t       imm_op, imm_target;
  alu_op_e     alu_op;
  logic        rd_we, illegal, use_imm;
  operands_t   ops;
  xlen_t       regs_q [`NR_REGS];

  // issue register
  logic        valid_q;
  xlen_t       pc_q, target_q;
  alu_op_e     alu_op_q;
  reg_idx_t    rd_q;
  logic        rd_we_q, illegal_q;
  operands_t   ops_q;

  assign instr  = fetch_entry_i.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ----------------------------------------------------------------------
  // decoder
  // ----------------------------------------------------------------------
  always_comb begin
    alu_op     = ALU_ADD;
    rd_we      = 1'b0;
    illegal    = 1'b0;
    use_imm    = 1'b0;
    imm_op     = imm_i;
    imm_target = imm_b;
    case (opcode)
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        rd_we   = 1'b1;
        use_imm = 1'b1;
        imm_op  = imm_u;
      end
      OPC_JAL: begin
        alu_op     = ALU_LINK;
        rd_we      = 1'b1;
        imm_target = imm_j;
      end
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  alu_op  = ALU_BEQ;
          3'b001:  alu_op  = ALU_BNE;
          default: illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        rd_we   = 1'b1;
        case (funct3)
          3'b000:  alu_op  = ALU_ADD;
          3'b100:  alu_op  = ALU_XOR;
          3'b110:  alu_op  = ALU_OR;
          3'b111:  alu_op  = ALU_AND;
          default: illegal = 1'b1;
        endcase
      end
      OPC_OP: begin
        rd_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op  = ALU_ADD;
          10'b0100000_000: alu_op  = ALU_SUB;
          10'b0000000_100: alu_op  = ALU_XOR;
          10'b0000000_110: alu_op  = ALU_OR;
          10'b0000000_111: alu_op  = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      rd_we = 1'b0;
    end
  end

  // newest value wins: execute, then write port, then register file
  function automatic xlen_t read_src(input reg_idx_t idx);
    xlen_t val;
    val = regs_q[idx];
    if (wb_we_i && wb_rd_i == idx) val = wb_data_i;
    if (ex_fwd_i.valid && ex_fwd_i.we && ex_fwd_i.rd == idx) val = ex_fwd_i.result;
    if (idx == '0) val = '0;
    return val;
  endfunction

  always_comb begin
    ops.a = read_src(rs1);
    ops.b = use_imm ? imm_op : read_src(rs2);
  end

  // x0 is never written, commit masks it
  always_ff @(posedge clk_i) begin
    if (wb_we_i) regs_q[wb_rd_i] <= wb_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) valid_q <= 1'b0;
    else         valid_q <= fetch_entry_i.valid & ~flush_i;
  end

  always_ff @(posedge clk_i) begin
    pc_q      <= fetch_entry_i.pc;
    target_q  <= fetch_entry_i.pc + imm_target;
    alu_op_q  <= alu_op;
    rd_q      <= rd;
    rd_we_q   <= rd_we;
    illegal_q <= illegal;
    ops_q     <= ops;
  end

  assign issue.valid         = valid_q;
  assign issue.pc            = pc_q;
  assign issue.alu_op        = alu_op_q;
  assign issue.rd            = rd_q;
  assign issue.rd_we         = rd_we_q;
  assign issue.operand_a     = ops_q.a;
  assign issue.operand_b     = ops_q.b;
  assign issue.branch_target = target_q;
  assign issue.illegal       = illegal_q;

endmodule

`default_nettype wire

//--- ex_stage.sv
// ----------------------------------------------------------------------
// execute stage
// alu, branch and jump resolution, result towards commit
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ex_stage import core_pkg::*; (
  issue_if.issue_dst issue,
  input  logic       exc_redirect_i,
  commit_if.ex_src   ex_out,
  output logic       branch_redirect_o,
  output xlen_t      branch_target_o
);

  xlen_t result;
  logic  taken;
  logic  ex_valid;

  // ----------------------------------------------------------------------
  // alu
  // ----------------------------------------------------------------------
  always_comb begin
    result = '0;
    taken  = 1'b0;
    case (issue.alu_op)
      ALU_ADD:    result = issue.operand_a + issue.operand_b;
      ALU_SUB:    result = issue.operand_a - issue.operand_b;
      ALU_XOR:    result = issue.operand_a ^ issue.operand_b;
      ALU_OR:     result = issue.operand_a | issue.operand_b;
      ALU_AND:    result = issue.operand_a & issue.operand_b;
      // lui immediate arrives on operand b
      ALU_PASS_B: result = issue.operand_b;
      ALU_LINK: begin
        result = issue.pc + xlen_t'(4);
        taken  = 1'b1;
      end
      ALU_BEQ:    taken = (issue.operand_a == issue.operand_b);
      ALU_BNE:    taken = (issue.operand_a != issue.operand_b);
      default:    result = '0;
    endcase
  end

  // a trap at commit kills whatever sits here
  assign ex_valid = issue.valid & ~exc_redirect_i;

  // predicted not taken, so any taken branch or jal redirects
  assign branch_redirect_o = ex_valid & taken & ~issue.illegal;
  assign branch_target_o   = issue.branch_target;

  assign ex_out.valid   = ex_valid;
  assign ex_out.pc      = issue.pc;
  assign ex_out.rd      = issue.rd;
  assign ex_out.we      = issue.rd_we;
  assign ex_out.result  = result;
  assign ex_out.illegal = issue.illegal;

endmodule

`default_nettype wire

//--- commit_stage.sv
// ----------------------------------------------------------------------
// commit stage
// commit register, write-back, trace outputs, exception redirect
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module commit_stage import core_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  commit_if.commit_dst  ex_in,
  // register write port
  output logic          wb_we_o,
  output reg_idx_t      wb_rd_o,
  output xlen_t         wb_data_o,
  output logic          exc_redirect_o,
  // commit trace
  output logic          commit_valid_o,
  output logic          commit_exc_o,
  output logic          commit_we_o,
  output xlen_t         commit_pc_o,
  output reg_idx_t      commit_rd_o,
  output xlen_t         commit_wdata_o
);

  logic     valid_q, we_q, illegal_q;
  xlen_t    pc_q, result_q;
  reg_idx_t rd_q;
  logic     exc, we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) valid_q <= 1'b0;
    else         valid_q <= ex_in.valid;
  end

  always_ff @(posedge clk_i) begin
    pc_q      <= ex_in.pc;
    rd_q      <= ex_in.rd;
    we_q      <= ex_in.we;
    result_q  <= ex_in.result;
    illegal_q <= ex_in.illegal;
  end

  assign exc = valid_q & illegal_q;
  // no write for x0 or a trapping instruction
  assign we  = valid_q & we_q & ~illegal_q & (rd_q != '0);

  assign exc_redirect_o = exc;

  assign wb_we_o   = we;
  assign wb_rd_o   = rd_q;
  assign wb_data_o = result_q;

  assign commit_valid_o = valid_q;
  assign commit_exc_o   = exc;
  assign commit_we_o    = we;
  assign commit_pc_o    = pc_q;
  assign commit_rd_o    = rd_q;
  assign commit_wdata_o = result_q;

endmodule

`default_nettype wire

//--- core_top.sv
// ----------------------------------------------------------------------
// core top level
// frontend, decode/issue, execute and commit with plain ports
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // instruction port
  output xlen_t       imem_addr_o,
  input  logic [31:0] imem_rdata_i,
  // commit trace
  output logic        commit_valid_o,
  output xlen_t       commit_pc_o,
  output logic        commit_exc_o,
  output logic        commit_we_o,
  output reg_idx_t    commit_rd_o,
  output xlen_t       commit_wdata_o
);

  // ----------------------------------------------------------------------
  // stage wiring
  // ----------------------------------------------------------------------
  fetch_entry_t fetch_entry;
  logic         branch_redirect;
  xlen_t        branch_target;
  logic         exc_redirect;
  logic         flush;
  logic         wb_we;
  reg_idx_t     wb_rd;
  xlen_t        wb_data;

  issue_if  issue_bus ();
  commit_if commit_bus ();

  // either redirect empties decode
  assign flush = branch_redirect | exc_redirect;

  frontend frontend_i (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .branch_redirect_i ( branch_redirect ),
    .branch_target_i   ( branch_target   ),
    .exc_redirect_i    ( exc_redirect    ),
    .imem_addr_o       ( imem_addr_o     ),
    .imem_rdata_i      ( imem_rdata_i    ),
    .fetch_entry_o     ( fetch_entry     )
  );

  id_stage id_stage_i (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .fetch_entry_i ( fetch_entry ),
    .flush_i       ( flush       ),
    .wb_we_i       ( wb_we       ),
    .wb_rd_i       ( wb_rd       ),
    .wb_data_i     ( wb_data     ),
    .ex_fwd_i      ( commit_bus  ),
    .issue         ( issue_bus   )
  );

  ex_stage ex_stage_i (
    .issue             ( issue_bus       ),
    .exc_redirect_i    ( exc_redirect    ),
    .ex_out            ( commit_bus      ),
    .branch_redirect_o ( branch_redirect ),
    .branch_target_o   ( branch_target   )
  );

  commit_stage commit_stage_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ex_in          ( commit_bus     ),
    .wb_we_o        ( wb_we          ),
    .wb_rd_o        ( wb_rd          ),
    .wb_data_o      ( wb_data        ),
    .exc_redirect_o ( exc_redirect   ),
    .commit_valid_o ( commit_valid_o ),
    .commit_exc_o   ( commit_exc_o   ),
    .commit_we_o    ( commit_we_o    ),
    .commit_pc_o    ( commit_pc_o    ),
    .commit_rd_o    ( commit_rd_o    ),
    .commit_wdata_o ( commit_wdata_o )
  );

endmodule

`default_nettype wire

//--- tb_core.sv
// ----------------------------------------------------------------------
// testbench for the core
// instruction memory, program and expected-commit tables,
// compare tasks, clock and reset
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module tb_core import core_pkg::*; ();

  localparam int IMEM_WORDS     = 128;
  localparam int COMMIT_TIMEOUT = 20;

  typedef struct packed {
    xlen_t       addr;
    logic [31:0] word;
  } prog_row_t;

  typedef struct packed {
    xlen_t    pc;
    logic     exc;
    logic     we;
    reg_idx_t rd;
    xlen_t    wdata;
  } commit_row_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  xlen_t       imem_addr;
  logic [31:0] imem_rdata = '0;
  logic        commit_valid, commit_exc, commit_we;
  xlen_t       commit_pc, commit_wdata;
  reg_idx_t    commit_rd;

  logic [31:0] imem [IMEM_WORDS];
  logic [6:0]  last_word = '0;
  prog_row_t   prog [$];
  commit_row_t exp_rows [$];

  core_top core_top_i (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .imem_addr_o    ( imem_addr    ),
    .imem_rdata_i   ( imem_rdata   ),
    .commit_valid_o ( commit_valid ),
    .commit_pc_o    ( commit_pc    ),
    .commit_exc_o   ( commit_exc   ),
    .commit_we_o    ( commit_we    ),
    .commit_rd_o    ( commit_rd    ),
    .commit_wdata_o ( commit_wdata )
  );

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  // word for last cycle's address seen by the core at the next rising edge
  always @(negedge clk_i) begin
    imem_rdata <= imem[last_word];
    last_word  <= imem_addr[8:2];
  end

  // ----------------------------------------------------------------------
  // instruction encoders
  // ----------------------------------------------------------------------
  function automatic logic [31:0] alu_imm(input logic [2:0] f3, input reg_idx_t rd,
                                          input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] alu_reg(input logic [6:0] f7, input logic [2:0] f3,
                                          input reg_idx_t rd, input reg_idx_t rs1,
                                          input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] lui_instr(input reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] branch_instr(input logic [2:0] f3, input reg_idx_t rs1,
                                               input reg_idx_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_instr(input reg_idx_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // ----------------------------------------------------------------------
  // tables
  // ----------------------------------------------------------------------
  task automatic add_instr(input xlen_t addr, input logic [31:0] word);
    prog_row_t row;
    row.addr = addr;
    row.word = word;
    prog.push_back(row);
  endtask

  task automatic expect_commit(input xlen_t pc, input logic exc, input logic we,
                               input reg_idx_t rd, input xlen_t wdata);
    commit_row_t row;
    row.pc    = pc;
    row.exc   = exc;
    row.we    = we;
    row.rd    = rd;
    row.wdata = wdata;
    exp_rows.push_back(row);
  endtask

  // unused words hold all-zero opcodes so a stray fetch would trap
  task automatic fill_imem();
    xlen_t a;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      a = xlen_t'(i) << 2;
      imem[i] = {a[24:0], 7'b0000000};
    end
  endtask

  task automatic load_program();
    add_instr(32'h00, lui_instr(5'd1, 20'h12345));
    add_instr(32'h04, alu_imm(3'b000, 5'd2, 5'd0, 12'd100));
    add_instr(32'h08, alu_imm(3'b000, 5'd3, 5'd2, 12'hFFF));
    add_instr(32'h0C, alu_imm(3'b100, 5'd4, 5'd3, 12'h0F0));
    add_instr(32'h10, alu_imm(3'b110, 5'd5, 5'd4, 12'h700));
    add_instr(32'h14, alu_imm(3'b111, 5'd6, 5'd5, 12'h0FF));
    add_instr(32'h18, alu_reg(7'b0000000, 3'b000, 5'd7, 5'd1, 5'd6));
    add_instr(32'h1C, alu_reg(7'b0100000, 3'b000, 5'd8, 5'd7, 5'd2));
    add_instr(32'h20, alu_reg(7'b0000000, 3'b100, 5'd9, 5'd8, 5'd4));
    add_instr(32'h24, alu_reg(7'b0000000, 3'b110, 5'd10, 5'd9, 5'd3));
    add_instr(32'h28, alu_reg(7'b0000000, 3'b111, 5'd11, 5'd10, 5'd5));
    add_instr(32'h2C, alu_imm(3'b000, 5'd0, 5'd1, 12'd5));
    add_instr(32'h30, alu_reg(7'b0000000, 3'b000, 5'd12, 5'd0, 5'd2));
    add_instr(32'h34, alu_reg(7'b0100000, 3'b000, 5'd13, 5'd2, 5'd3));
    // x12 is two instructions back and comes through the write port
    add_instr(32'h38, alu_reg(7'b0100000, 3'b000, 5'd14, 5'd3, 5'd12));
    add_instr(32'h3C, branch_instr(3'b001, 5'd2, 5'd12, 13'd16));
    add_instr(32'h40, branch_instr(3'b000, 5'd2, 5'd12, 13'd12));
    // shadow of the taken beq
    add_instr(32'h44, alu_imm(3'b000, 5'd15, 5'd0, 12'd1));
    add_instr(32'h48, alu_imm(3'b000, 5'd15, 5'd0, 12'd2));
    add_instr(32'h4C, alu_imm(3'b000, 5'd15, 5'd0, 12'h055));
    add_instr(32'h50, jal_instr(5'd1, 21'd16));
    add_instr(32'h54, alu_imm(3'b000, 5'd16, 5'd0, 12'd3));
    add_instr(32'h58, alu_imm(3'b000, 5'd16, 5'd0, 12'd4));
    add_instr(32'h60, alu_imm(3'b000, 5'd17, 5'd1, 12'd4));
    add_instr(32'h64, 32'hFFFF_FFFF);
    add_instr(32'h68, alu_imm(3'b000, 5'd18, 5'd0, 12'd7));
    // trap routine ending in a jump to itself
    add_instr(`TRAP_VECTOR, alu_imm(3'b000, 5'd20, 5'd17, 12'h100));
    add_instr(`TRAP_VECTOR + 32'd4, alu_reg(7'b0000000, 3'b100, 5'd21, 5'd20, 5'd15));
    add_instr(`TRAP_VECTOR + 32'd8, jal_instr(5'd0, 21'd0));
  endtask

  task automatic load_expected();
    expect_commit(32'h00, 1'b0, 1'b1, 5'd1, 32'h1234_5000);
    expect_commit(32'h04, 1'b0, 1'b1, 5'd2, 32'h0000_0064);
    expect_commit(32'h08, 1'b0, 1'b1, 5'd3, 32'h0000_0063);
    expect_commit(32'h0C, 1'b0, 1'b1, 5'd4, 32'h0000_0093);
    expect_commit(32'h10, 1'b0, 1'b1, 5'd5, 32'h0000_0793);
    expect_commit(32'h14, 1'b0, 1'b1, 5'd6, 32'h0000_0093);
    expect_commit(32'h18, 1'b0, 1'b1, 5'd7, 32'h1234_5093);
    expect_commit(32'h1C, 1'b0, 1'b1, 5'd8, 32'h1234_502F);
    expect_commit(32'h20, 1'b0, 1'b1, 5'd9, 32'h1234_50BC);
    expect_commit(32'h24, 1'b0, 1'b1, 5'd10, 32'h1234_50FF);
    expect_commit(32'h28, 1'b0, 1'b1, 5'd11, 32'h0000_0093);
    expect_commit(32'h2C, 1'b0, 1'b0, 5'd0, 32'h0);
    expect_commit(32'h30, 1'b0, 1'b1, 5'd12, 32'h0000_0064);
    expect_commit(32'h34, 1'b0, 1'b1, 5'd13, 32'h0000_0001);
    expect_commit(32'h38, 1'b0, 1'b1, 5'd14, 32'hFFFF_FFFF);
    expect_commit(32'h3C, 1'b0, 1'b0, 5'd0, 32'h0);
    expect_commit(32'h40, 1'b0, 1'b0, 5'd0, 32'h0);
    expect_commit(32'h4C, 1'b0, 1'b1, 5'd15, 32'h0000_0055);
    expect_commit(32'h50, 1'b0, 1'b1, 5'd1, 32'h0000_0054);
    expect_commit(32'h60, 1'b0, 1'b1, 5'd17, 32'h0000_0058);
    expect_commit(32'h64, 1'b1, 1'b0, 5'd0, 32'h0);
    expect_commit(`TRAP_VECTOR, 1'b0, 1'b1, 5'd20, 32'h0000_0158);
    expect_commit(`TRAP_VECTOR + 32'd4, 1'b0, 1'b1, 5'd21, 32'h0000_010D);
    expect_commit(`TRAP_VECTOR + 32'd8, 1'b0, 1'b0, 5'd0, 32'h0);
    expect_commit(`TRAP_VECTOR + 32'd8, 1'b0, 1'b0, 5'd0, 32'h0);
    expect_commit(`TRAP_VECTOR + 32'd8, 1'b0, 1'b0, 5'd0, 32'h0);
  endtask

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // next commit sampled at the falling edge
  task automatic await_commit(input int row);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!commit_valid) begin
      cycles++;
      if (cycles > COMMIT_TIMEOUT) begin
        $display("no commit for row %0d within %0d cycles", row, COMMIT_TIMEOUT);
        stop_run();
      end
      @(negedge clk_i);
    end
  endtask

  initial begin
    rst_ni = 1'b0;
    fill_imem();
    load_program();
    for (int i = 0; i < prog.size(); i++) begin
      imem[prog[i].addr[8:2]] = prog[i].word;
    end
    load_expected();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < exp_rows.size(); i++) begin
      await_commit(i);
      check_word("commit_pc_o", commit_pc, exp_rows[i].pc);
      check_bit("commit_exc_o", commit_exc, exp_rows[i].exc);
      check_bit("commit_we_o", commit_we, exp_rows[i].we);
      // rd and data only carry meaning on a register write
      if (exp_rows[i].we) begin
        check_reg("commit_rd_o", commit_rd, exp_rows[i].rd);
        check_word("commit_wdata_o", commit_wdata, exp_rows[i].wdata);
      end
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
core_pkg.sv
core_ifs.sv
frontend.sv
id_stage.sv
ex_stage.sv
commit_stage.sv
core_top.sv
tb_core.sv

//--- Makefile
TOP := tb_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f project.f --Mdir obj_dir -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
